// ==== verilog/sdram_geom_pkg.sv ====
// SDRAM geometry and command types

package sdram_geom_pkg;

  //////////////////////////////
  // Address geometry
  //////////////////////////////
  localparam int BA_W      = 2;
  localparam int NUM_BANKS = 1 << BA_W;
  localparam int ROW_W     = 11;
  localparam int COL_W     = 8;
  localparam int ADDR_W    = 11;
  // Selects all banks on PRE
  localparam int AP_BIT    = 10;
  localparam int DQ_W      = 16;

  typedef logic [BA_W-1:0]   ba_t;
  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [COL_W-1:0]  col_t;
  typedef logic [ADDR_W-1:0] sdram_addr_t;
  typedef logic [DQ_W-1:0]   dq_t;

  typedef enum logic [2:0] {
    CMD_NOP = 3'd0,
    CMD_ACT = 3'd1,
    CMD_RD  = 3'd2,
    CMD_WR  = 3'd3,
    CMD_PRE = 3'd4,
    CMD_REF = 3'd5
  } sdram_cmd_e;

  typedef enum logic {
    ST_IDLE     = 1'b0,
    ST_REF_WAIT = 1'b1
  } sched_state_e;

endpackage : sdram_geom_pkg

// ==== verilog/sdram_timing_pkg.sv ====
// SDRAM timing values

package sdram_timing_pkg;

  //////////////////////////////
  // Core timing, in clock cycles
  //////////////////////////////
  localparam int T_RCD       = 3;
  localparam int T_RP        = 3;
  localparam int T_RAS       = 6;
  localparam int T_WR        = 2;
  localparam int T_RRD       = 2;
  localparam int T_RFC       = 8;
  localparam int CAS_LATENCY = 2;

  // One extra cycle for the rdata_o register
  localparam int RD_LATENCY  = CAS_LATENCY + 1;

  // Short interval so refresh shows up early in simulation
  localparam int REFRESH_INTERVAL = 120;

  // Counter widths
  localparam int TIMER_W   = $clog2(T_RFC + 1);
  localparam int REF_CNT_W = 8;

  typedef logic [TIMER_W-1:0]   timer_t;
  typedef logic [REF_CNT_W-1:0] ref_cnt_t;

endpackage : sdram_timing_pkg

// ==== verilog/sdram_bank_if.sv ====
// Bank state interface
`timescale 1ns/10ps

interface sdram_bank_if
  import sdram_geom_pkg::*;
();

  // Command strobes from the FSM
  logic                 act_o;
  logic                 pre_o;
  logic                 pre_all_o;
  logic                 wr_o;
  ba_t                  sel_ba;
  row_t                 act_row;

  // Bank status from the tracker
  logic [NUM_BANKS-1:0] bank_open;
  row_t                 open_row [NUM_BANKS];
  logic [NUM_BANKS-1:0] rcd_ok;
  logic [NUM_BANKS-1:0] pre_ok;
  logic [NUM_BANKS-1:0] act_ok;
  logic                 rrd_ok;

  modport fsm (
    output act_o, pre_o, pre_all_o, wr_o, sel_ba, act_row,
    input  bank_open, open_row, rcd_ok, pre_ok, act_ok, rrd_ok
  );

  modport tracker (
    input  act_o, pre_o, pre_all_o, wr_o, sel_ba, act_row,
    output bank_open, open_row, rcd_ok, pre_ok, act_ok, rrd_ok
  );

endinterface : sdram_bank_if

// ==== verilog/sdram_bank_tracker.sv ====
// Bank row and timing tracker
`timescale 1ns/10ps

module sdram_bank_tracker
  import sdram_geom_pkg::*;
  import sdram_timing_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  sdram_bank_if.tracker    bank_if
);

  timer_t rcd_cnt [NUM_BANKS];
  timer_t ras_cnt [NUM_BANKS];
  timer_t rp_cnt  [NUM_BANKS];
  timer_t wr_cnt  [NUM_BANKS];
  timer_t rrd_cnt;

  // Count down and hold at zero
  function automatic timer_t tick(input timer_t cnt);
    return (cnt == '0) ? cnt : timer_t'(cnt - 1'b1);
  endfunction

  //////////////////////////////
  // Per-bank state and timers
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      bank_if.bank_open <= '0;
      for (int b = 0; b < NUM_BANKS; b++)
      begin
        rcd_cnt[b] <= '0;
        ras_cnt[b] <= '0;
        rp_cnt[b]  <= '0;
        wr_cnt[b]  <= '0;
      end
      rrd_cnt <= '0;
    end
    else
    begin
      for (int b = 0; b < NUM_BANKS; b++)
      begin
        rcd_cnt[b] <= tick(rcd_cnt[b]);
        ras_cnt[b] <= tick(ras_cnt[b]);
        rp_cnt[b]  <= tick(rp_cnt[b]);
        wr_cnt[b]  <= tick(wr_cnt[b]);

        if (bank_if.act_o && (bank_if.sel_ba == ba_t'(b)))
        begin
          rcd_cnt[b]           <= timer_t'(T_RCD);
          ras_cnt[b]           <= timer_t'(T_RAS);
          bank_if.bank_open[b] <= 1'b1;
        end

        if ((bank_if.pre_o && (bank_if.sel_ba == ba_t'(b))) || bank_if.pre_all_o)
        begin
          rp_cnt[b]            <= timer_t'(T_RP);
          bank_if.bank_open[b] <= 1'b0;
        end

        if (bank_if.wr_o && (bank_if.sel_ba == ba_t'(b)))
          wr_cnt[b] <= timer_t'(T_WR);
      end

      // tRRD is shared by all banks
      rrd_cnt <= bank_if.act_o ? timer_t'(T_RRD) : tick(rrd_cnt);
    end
  end

  // Row address of the open page
  always_ff @(posedge clk_i)
  begin
    if (bank_if.act_o)
      bank_if.open_row[bank_if.sel_ba] <= bank_if.act_row;
  end

  //////////////////////////////
  // Ok flags
  //////////////////////////////
  always_comb
  begin
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      bank_if.rcd_ok[b] = (rcd_cnt[b] == '0);
      bank_if.pre_ok[b] = (ras_cnt[b] == '0) && (wr_cnt[b] == '0);
      bank_if.act_ok[b] = (rp_cnt[b] == '0) && !bank_if.bank_open[b];
    end
  end

  assign bank_if.rrd_ok = (rrd_cnt == '0);

endmodule : sdram_bank_tracker

// ==== verilog/sdram_refresh_timer.sv ====
// Refresh interval timer
`timescale 1ns/10ps

module sdram_refresh_timer
  import sdram_timing_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ref_issued_i,
  output logic ref_due_o,
  output logic rfc_ok_o
);

  ref_cnt_t ref_cnt_q;
  logic     pending_q;
  timer_t   rfc_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ref_cnt_q <= ref_cnt_t'(REFRESH_INTERVAL);
      pending_q <= 1'b0;
      rfc_cnt_q <= '0;
    end
    else
    begin
      // Free running, reloads on expiry
      if (ref_cnt_q == '0)
        ref_cnt_q <= ref_cnt_t'(REFRESH_INTERVAL);
      else
        ref_cnt_q <= ref_cnt_q - 1'b1;

      // Only one refresh is ever pending
      if (ref_cnt_q == '0)
        pending_q <= 1'b1;
      else if (ref_issued_i)
        pending_q <= 1'b0;

      if (ref_issued_i)
        rfc_cnt_q <= timer_t'(T_RFC);
      else if (rfc_cnt_q != '0)
        rfc_cnt_q <= rfc_cnt_q - 1'b1;
    end
  end

  assign ref_due_o = pending_q;
  assign rfc_ok_o  = (rfc_cnt_q == '0);

endmodule : sdram_refresh_timer

// ==== verilog/sdram_cmd_fsm.sv ====
// SDRAM command decision FSM
`timescale 1ns/10ps

module sdram_cmd_fsm
  import sdram_geom_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic        we_i,
  input  ba_t         ba_i,
  input  row_t        row_i,
  input  col_t        col_i,
  input  dq_t         wdata_i,
  sdram_bank_if.fsm   bank_if,
  input  logic        ref_due_i,
  input  logic        rfc_ok_i,
  output logic        ref_issued_o,
  output logic        rd_issued_o,
  output logic        ack_o,
  output sdram_cmd_e  sdram_cmd_o,
  output ba_t         sdram_ba_o,
  output sdram_addr_t sdram_addr_o,
  output dq_t         sdram_dq_o,
  output logic        sdram_dqoe_o
);

  sched_state_e state_q;
  sched_state_e state_d;
  sdram_cmd_e   cmd_d;
  sdram_addr_t  addr_d;
  logic         req_live;
  logic         row_hit;

  // The request still on req_i in the ack cycle is already served
  assign req_live = req_i && !ack_o;
  assign row_hit  = bank_if.bank_open[ba_i] && (bank_if.open_row[ba_i] == row_i);

  // Strobes act on the edge that registers the command
  assign bank_if.sel_ba    = ba_i;
  assign bank_if.act_row   = row_i;
  assign bank_if.act_o     = (cmd_d == CMD_ACT);
  assign bank_if.pre_o     = (cmd_d == CMD_PRE) && !addr_d[AP_BIT];
  assign bank_if.pre_all_o = (cmd_d == CMD_PRE) && addr_d[AP_BIT];
  assign bank_if.wr_o      = (cmd_d == CMD_WR);
  assign ref_issued_o      = (cmd_d == CMD_REF);

  //////////////////////////////
  // Next command
  //////////////////////////////
  always_comb
  begin
    state_d = state_q;
    cmd_d   = CMD_NOP;
    addr_d  = '0;

    case (state_q)
      ST_IDLE:
      begin
        if (ref_due_i)
        begin
          // Refresh wins, close all pages first
          if (rfc_ok_i && (bank_if.bank_open == '0) && (&bank_if.act_ok))
            cmd_d = CMD_REF;
          else if (rfc_ok_i && (bank_if.bank_open != '0) && (&bank_if.pre_ok))
          begin
            cmd_d          = CMD_PRE;
            addr_d[AP_BIT] = 1'b1;
            state_d        = ST_REF_WAIT;
          end
        end
        else if (req_live && rfc_ok_i)
        begin
          if (row_hit)
          begin
            if (bank_if.rcd_ok[ba_i])
            begin
              cmd_d  = we_i ? CMD_WR : CMD_RD;
              addr_d = sdram_addr_t'(col_i);
            end
          end
          else if (bank_if.bank_open[ba_i])
          begin
            // Wrong row open
            if (bank_if.pre_ok[ba_i])
              cmd_d = CMD_PRE;
          end
          else if (bank_if.act_ok[ba_i] && bank_if.rrd_ok)
          begin
            cmd_d  = CMD_ACT;
            addr_d = sdram_addr_t'(row_i);
          end
        end
      end

      ST_REF_WAIT:
      begin
        // All banks closed, so act_ok only waits on tRP
        if (&bank_if.act_ok)
        begin
          cmd_d   = CMD_REF;
          state_d = ST_IDLE;
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

  //////////////////////////////
  // Output registers
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q      <= ST_IDLE;
      sdram_cmd_o  <= CMD_NOP;
      ack_o        <= 1'b0;
      rd_issued_o  <= 1'b0;
      sdram_dqoe_o <= 1'b0;
    end
    else
    begin
      state_q      <= state_d;
      sdram_cmd_o  <= cmd_d;
      ack_o        <= (cmd_d == CMD_RD) || (cmd_d == CMD_WR);
      rd_issued_o  <= (cmd_d == CMD_RD);
      sdram_dqoe_o <= (cmd_d == CMD_WR);
    end
  end

  always_ff @(posedge clk_i)
  begin
    sdram_ba_o   <= ba_i;
    sdram_addr_o <= addr_d;
    sdram_dq_o   <= wdata_i;
  end

endmodule : sdram_cmd_fsm

// ==== verilog/sdram_rd_valid_pipe.sv ====
// Read data valid pipeline
`timescale 1ns/10ps

module sdram_rd_valid_pipe
  import sdram_geom_pkg::*;
  import sdram_timing_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic rd_issued_i,
  input  dq_t  sdram_dq_i,
  output dq_t  rdata_o,
  output logic rvalid_o
);

  // One bit per cycle of read latency
  logic [RD_LATENCY-1:0] vld_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      vld_q <= '0;
    else
      vld_q <= {vld_q[RD_LATENCY-2:0], rd_issued_i};
  end

  // DQ is on the pins CAS_LATENCY cycles after RD
  always_ff @(posedge clk_i)
  begin
    if (vld_q[CAS_LATENCY-1])
      rdata_o <= sdram_dq_i;
  end

  assign rvalid_o = vld_q[RD_LATENCY-1];

endmodule : sdram_rd_valid_pipe

// ==== verilog/sdram_sched_top.sv ====
// SDRAM command scheduler top
`timescale 1ns/10ps

module sdram_sched_top
  import sdram_geom_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // Request side
  input  logic        req_i,
  input  logic        we_i,
  input  ba_t         ba_i,
  input  row_t        row_i,
  input  col_t        col_i,
  input  dq_t         wdata_i,
  output logic        ack_o,
  output dq_t         rdata_o,
  output logic        rvalid_o,

  // SDRAM side
  output sdram_cmd_e  sdram_cmd_o,
  output ba_t         sdram_ba_o,
  output sdram_addr_t sdram_addr_o,
  input  dq_t         sdram_dq_i,
  output dq_t         sdram_dq_o,
  output logic        sdram_dqoe_o
);

  logic ref_due;
  logic rfc_ok;
  logic ref_issued;
  logic rd_issued;

  sdram_bank_if bank_if ();

  sdram_bank_tracker u_tracker (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .bank_if (bank_if.tracker)
  );

  sdram_refresh_timer u_refresh (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ref_issued_i (ref_issued),
    .ref_due_o    (ref_due),
    .rfc_ok_o     (rfc_ok)
  );

  sdram_cmd_fsm u_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .we_i         (we_i),
    .ba_i         (ba_i),
    .row_i        (row_i),
    .col_i        (col_i),
    .wdata_i      (wdata_i),
    .bank_if      (bank_if.fsm),
    .ref_due_i    (ref_due),
    .rfc_ok_i     (rfc_ok),
    .ref_issued_o (ref_issued),
    .rd_issued_o  (rd_issued),
    .ack_o        (ack_o),
    .sdram_cmd_o  (sdram_cmd_o),
    .sdram_ba_o   (sdram_ba_o),
    .sdram_addr_o (sdram_addr_o),
    .sdram_dq_o   (sdram_dq_o),
    .sdram_dqoe_o (sdram_dqoe_o)
  );

  sdram_rd_valid_pipe u_rd_pipe (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_issued_i (rd_issued),
    .sdram_dq_i  (sdram_dq_i),
    .rdata_o     (rdata_o),
    .rvalid_o    (rvalid_o)
  );

endmodule : sdram_sched_top

// ==== tb/sdram_sched_tests.svh ====
// SDRAM scheduler directed tests

//////////////////////////////
// Request helpers
//////////////////////////////
// One request, held until ack; reads also wait for rvalid
task automatic access(input logic wr, input ba_t b, input row_t r, input col_t c,
                      input dq_t wd, input dq_t exp_rd, output int ack_cyc);
  int n;
  @(posedge clk);
  req   <= 1'b1;
  we    <= wr;
  ba    <= b;
  row   <= r;
  col   <= c;
  wdata <= wd;
  n = 0;
  do
  begin
    @(negedge clk);
    n++;
  end
  while (!ack && (n < WAIT_LIMIT));
  ack_cyc = cyc;
  assert (ack) else report_violation("timeout waiting for ack_o");
  if (ack)
    assert (open_row[b] == r) else report_mismatch("open row", open_row[b], r);
  @(posedge clk);
  req <= 1'b0;
  if (!wr)
  begin
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (!rvalid && (n < WAIT_LIMIT));
    assert (rvalid) else report_violation("timeout waiting for rvalid_o");
    assert (cyc - ack_cyc == RD_LATENCY)
      else report_mismatch("rvalid_o delay", cyc - ack_cyc, RD_LATENCY);
    assert (rdata == exp_rd) else report_mismatch("rdata_o", rdata, exp_rd);
  end
endtask

task automatic report_test(input string name, input int err_before);
  tests_run++;
  if (err_cnt == err_before)
    $display("%-20s ok", name);
  else
  begin
    tests_failed++;
    $display("%-20s FAILED, %0d errors", name, err_cnt - err_before);
  end
endtask

//////////////////////////////
// Tests
//////////////////////////////
task automatic closed_bank_access();
  int e0;
  int t0;
  int ack_cyc;
  e0 = err_cnt;
  t0 = cyc;
  assert (!open_bank[0]) else report_violation("bank 0 open before first access");
  access(1'b1, ba_t'(0), row_t'(11'h055), col_t'(8'h10), dq_t'(16'hbeef), '0, ack_cyc);
  assert (last_act[0] > t0) else report_violation("no ACT before the first access");
  assert (ack_cyc - last_act[0] >= T_RCD)
    else report_mismatch("ACT to WR spacing", ack_cyc - last_act[0], T_RCD);
  report_test("closed_bank", e0);
endtask

task automatic write_then_read();
  int   e0;
  int   ack_cyc;
  col_t c;
  dq_t  d;
  e0 = err_cnt;
  c  = col_t'($urandom);
  d  = dq_t'($urandom);
  access(1'b1, ba_t'(0), row_t'(11'h055), c, d, '0, ack_cyc);
  access(1'b0, ba_t'(0), row_t'(11'h055), c, '0, d, ack_cyc);
  report_test("write_read", e0);
endtask

// Row 0x055 is open in bank 0 from the earlier tests
task automatic row_miss_sequence();
  int  e0;
  int  t0;
  int  ack_cyc;
  dq_t d;
  e0 = err_cnt;
  t0 = cyc;
  d  = dq_t'($urandom);
  access(1'b1, ba_t'(0), row_t'(11'h2aa), col_t'(8'h33), d, '0, ack_cyc);
  assert (last_pre[0] > t0) else report_violation("no PRE before the row change");
  assert (last_act[0] > last_pre[0]) else report_violation("no ACT after PRE");
  assert (ack_cyc > last_act[0]) else report_violation("access not after ACT");
  access(1'b0, ba_t'(0), row_t'(11'h2aa), col_t'(8'h33), '0, d, ack_cyc);
  report_test("row_miss", e0);
endtask

task automatic all_banks_readback();
  int   e0;
  int   ack_cyc;
  row_t rows [NUM_BANKS];
  col_t cols [NUM_BANKS];
  dq_t  data [NUM_BANKS];
  e0 = err_cnt;
  for (int b = 0; b < NUM_BANKS; b++)
  begin
    rows[b] = row_t'($urandom);
    cols[b] = col_t'($urandom);
    data[b] = dq_t'($urandom);
    access(1'b1, ba_t'(b), rows[b], cols[b], data[b], '0, ack_cyc);
  end
  for (int b = 0; b < NUM_BANKS; b++)
    access(1'b0, ba_t'(b), rows[b], cols[b], '0, data[b], ack_cyc);
  report_test("all_banks", e0);
endtask

task automatic refresh_coverage();
  int   e0;
  int   r0;
  int   p0;
  int   ack_cyc;
  ba_t  b;
  row_t r;
  col_t c;
  dq_t  d;
  e0 = err_cnt;
  r0 = ref_cnt;
  p0 = pre_all_cnt;
  // Leave bank 2 open across the idle window
  access(1'b1, ba_t'(2), row_t'(11'h123), col_t'(8'h45), dq_t'(16'h5a5a), '0, ack_cyc);
  repeat (2 * REFRESH_INTERVAL + REF_MARGIN) @(posedge clk);
  assert (ref_cnt - r0 >= 2) else report_mismatch("REF count idle", ref_cnt - r0, 2);
  assert (pre_all_cnt > p0) else report_violation("no precharge-all before REF");
  r0 = ref_cnt;
  repeat (24)
  begin
    b = ba_t'($urandom);
    r = row_t'($urandom);
    c = col_t'($urandom);
    d = dq_t'($urandom);
    access(1'b1, b, r, c, d, '0, ack_cyc);
    access(1'b0, b, r, c, '0, d, ack_cyc);
  end
  assert (ref_cnt > r0) else report_violation("no REF during traffic");
  report_test("refresh", e0);
endtask

// ==== tb/sdram_sched_tb.sv ====
// SDRAM scheduler testbench
`timescale 1ns/10ps

module sdram_sched_tb
  import sdram_geom_pkg::*;
  import sdram_timing_pkg::*;
();

  localparam int WAIT_LIMIT = 200;
  localparam int REF_MARGIN = 40;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req;
  logic        we;
  ba_t         ba;
  row_t        row;
  col_t        col;
  dq_t         wdata;
  logic        ack;
  dq_t         rdata;
  logic        rvalid;
  sdram_cmd_e  cmd;
  ba_t         cmd_ba;
  sdram_addr_t cmd_addr;
  dq_t         dq_in;
  dq_t         dq_out;
  logic        dqoe;

  int cyc;
  int err_cnt;
  int tests_run;
  int tests_failed;

  // Behavioral SDRAM state
  dq_t                  mem [int];
  dq_t                  dq_sched [int];
  logic [NUM_BANKS-1:0] open_bank;
  row_t                 open_row [NUM_BANKS];
  int                   last_act [NUM_BANKS];
  int                   last_pre [NUM_BANKS];
  int                   last_wr  [NUM_BANKS];
  int                   last_act_any;
  int                   last_ref;
  int                   last_ref_seen;
  int                   ref_cnt;
  int                   pre_all_cnt;
  int                   mon_key;

  always #2 clk = ~clk;

  sdram_sched_top dut_i (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_i        (req),
    .we_i         (we),
    .ba_i         (ba),
    .row_i        (row),
    .col_i        (col),
    .wdata_i      (wdata),
    .ack_o        (ack),
    .rdata_o      (rdata),
    .rvalid_o     (rvalid),
    .sdram_cmd_o  (cmd),
    .sdram_ba_o   (cmd_ba),
    .sdram_addr_o (cmd_addr),
    .sdram_dq_i   (dq_in),
    .sdram_dq_o   (dq_out),
    .sdram_dqoe_o (dqoe)
  );

  task automatic report_violation(input string msg);
    $display("%s at cycle %0d", msg, cyc);
    err_cnt++;
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERR %s got %h expected %h at cycle %0d", sig, got, exp, cyc);
    err_cnt++;
  endtask

  always @(posedge clk)
    cyc <= cyc + 1;

  // Read data goes on the pins CAS_LATENCY cycles after RD
  always @(posedge clk)
  begin
    if (dq_sched.exists(cyc + 1))
    begin
      dq_in <= dq_sched[cyc + 1];
      dq_sched.delete(cyc + 1);
    end
  end

  //////////////////////////////
  // Command monitor and memory
  //////////////////////////////
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      assert (cyc - last_ref_seen <= REFRESH_INTERVAL + REF_MARGIN)
      else
      begin
        report_violation("refresh interval exceeded");
        last_ref_seen = cyc;
      end
      assert (dqoe == (cmd == CMD_WR)) else report_violation("sdram_dqoe_o outside WR");
      if (cmd != CMD_NOP)
        assert (cyc - last_ref >= T_RFC) else report_violation("command inside tRFC");
      case (cmd)
        CMD_ACT:
        begin
          assert (!open_bank[cmd_ba]) else report_violation("ACT to an open bank");
          assert (cyc - last_pre[cmd_ba] >= T_RP) else report_violation("tRP violated");
          assert (cyc - last_act_any >= T_RRD) else report_violation("tRRD violated");
          open_bank[cmd_ba] = 1'b1;
          open_row[cmd_ba]  = cmd_addr[ROW_W-1:0];
          last_act[cmd_ba]  = cyc;
          last_act_any      = cyc;
        end
        CMD_RD, CMD_WR:
        begin
          mon_key = int'({cmd_ba, open_row[cmd_ba], cmd_addr[COL_W-1:0]});
          assert (open_bank[cmd_ba]) else report_violation("access to a closed bank");
          assert (cyc - last_act[cmd_ba] >= T_RCD) else report_violation("tRCD violated");
          if (cmd == CMD_WR)
          begin
            mem[mon_key]    = dq_out;
            last_wr[cmd_ba] = cyc;
          end
          else
            dq_sched[cyc + CAS_LATENCY] = mem.exists(mon_key) ? mem[mon_key] : '0;
        end
        CMD_PRE:
        begin
          if (cmd_addr[AP_BIT])
            pre_all_cnt++;
          for (int b = 0; b < NUM_BANKS; b++)
          begin
            if (cmd_addr[AP_BIT] || (cmd_ba == ba_t'(b)))
            begin
              assert (cyc - last_act[b] >= T_RAS) else report_violation("tRAS violated");
              assert (cyc - last_wr[b] >= T_WR) else report_violation("tWR violated");
              open_bank[b] = 1'b0;
              last_pre[b]  = cyc;
            end
          end
        end
        CMD_REF:
        begin
          assert (open_bank == '0) else report_violation("REF with a bank open");
          for (int b = 0; b < NUM_BANKS; b++)
            assert (cyc - last_pre[b] >= T_RP) else report_violation("tRP before REF violated");
          last_ref      = cyc;
          last_ref_seen = cyc;
          ref_cnt++;
        end
        default: ;
      endcase
    end
  end

  `include "sdram_sched_tests.svh"

  initial
  begin
    void'($urandom(32'h12988f20));
    cyc           = 0;
    err_cnt       = 0;
    tests_run     = 0;
    tests_failed  = 0;
    open_bank     = '0;
    last_act_any  = -100;
    last_ref      = -100;
    last_ref_seen = 0;
    ref_cnt       = 0;
    pre_all_cnt   = 0;
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      last_act[b] = -100;
      last_pre[b] = -100;
      last_wr[b]  = -100;
      open_row[b] = '0;
    end
    rst_n = 1'b0;
    req   = 1'b0;
    we    = 1'b0;
    ba    = '0;
    row   = '0;
    col   = '0;
    wdata = '0;
    dq_in = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    closed_bank_access();
    write_then_read();
    row_miss_sequence();
    all_banks_readback();
    refresh_coverage();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule : sdram_sched_tb

// ==== sdram_sched.f ====
+incdir+tb
verilog/sdram_geom_pkg.sv
verilog/sdram_timing_pkg.sv
verilog/sdram_bank_if.sv
verilog/sdram_bank_tracker.sv
verilog/sdram_refresh_timer.sv
verilog/sdram_cmd_fsm.sv
verilog/sdram_rd_valid_pipe.sv
verilog/sdram_sched_top.sv
tb/sdram_sched_tb.sv
